// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = rv_core_tb
FILELIST = build.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q -x -F '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
+incdir+verif
source/rv_pkg.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_result.sv
source/rv_core.sv
verif/rv_core_tb.sv

// File: source/rv_core.sv
`timescale 1ns/100ps

module rv_core
(
    input  wire                              i_clk,
    input  wire                              i_reset,
    input  wire                              i_valid,
    input  wire [31:0]                       i_instruction,
    input  wire [rv_pkg::xlen-1:0]           i_pc,
    output logic                             o_wb_valid,
    output logic [rv_pkg::reg_addr_bits-1:0] o_wb_rd,
    output logic [rv_pkg::xlen-1:0]          o_wb_data,
    output logic                             o_wb_write,
    output logic                             o_branch_taken,
    output logic [rv_pkg::xlen-1:0]          o_branch_target,
    output logic                             o_illegal
);

    logic [rv_pkg::reg_addr_bits-1:0] rs1, rs2;
    logic [rv_pkg::xlen-1:0]          rs1_data, rs2_data;

    // decode register
    logic                             d_valid, d_reg_write, d_illegal;
    rv_pkg::alu_op_t                  d_alu_op;
    logic [rv_pkg::xlen-1:0]          d_op_a, d_op_b, d_rs1_val, d_rs2_val, d_imm, d_pc;
    logic [rv_pkg::reg_addr_bits-1:0] d_rd;
    logic [1:0]                       d_kind;

    // forward path out of execute
    logic                             ex_fwd_valid;
    logic [rv_pkg::reg_addr_bits-1:0] ex_fwd_rd;
    logic [rv_pkg::xlen-1:0]          ex_fwd_data;

    rv_decode u_decode (
        .i_clk(i_clk), .i_reset(i_reset), .i_valid(i_valid),
        .i_instruction(i_instruction), .i_pc(i_pc),
        .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
        .o_rs1(rs1), .o_rs2(rs2),
        .o_valid(d_valid), .o_alu_op(d_alu_op), .o_op_a(d_op_a), .o_op_b(d_op_b),
        .o_rs1_val(d_rs1_val), .o_rs2_val(d_rs2_val), .o_imm(d_imm), .o_pc(d_pc),
        .o_rd(d_rd), .o_reg_write(d_reg_write), .o_kind(d_kind), .o_illegal(d_illegal)
    );

    rv_execute u_execute (
        .i_clk(i_clk), .i_reset(i_reset), .i_valid(d_valid),
        .i_alu_op(d_alu_op), .i_op_a(d_op_a), .i_op_b(d_op_b),
        .i_rs1_val(d_rs1_val), .i_rs2_val(d_rs2_val), .i_imm(d_imm), .i_pc(d_pc),
        .i_rd(d_rd), .i_reg_write(d_reg_write), .i_kind(d_kind), .i_illegal(d_illegal),
        .o_fwd_valid(ex_fwd_valid), .o_fwd_rd(ex_fwd_rd), .o_fwd_data(ex_fwd_data),
        .o_wb_valid(o_wb_valid), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data),
        .o_wb_write(o_wb_write), .o_branch_taken(o_branch_taken),
        .o_branch_target(o_branch_target), .o_illegal(o_illegal)
    );

    rv_result u_result (
        .i_clk(i_clk), .i_reset(i_reset), .i_rs1(rs1), .i_rs2(rs2),
        .i_fwd_valid(ex_fwd_valid), .i_fwd_rd(ex_fwd_rd), .i_fwd_data(ex_fwd_data),
        .i_wb_valid(o_wb_valid), .i_wb_write(o_wb_write),
        .i_wb_rd(o_wb_rd), .i_wb_data(o_wb_data),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
    );

endmodule

// File: source/rv_decode.sv
`timescale 1ns/100ps

module rv_decode
(
    input  wire                              i_clk,
    input  wire                              i_reset,
    input  wire                              i_valid,
    input  wire [31:0]                       i_instruction,
    input  wire [rv_pkg::xlen-1:0]           i_pc,
    input  wire [rv_pkg::xlen-1:0]           i_rs1_data,
    input  wire [rv_pkg::xlen-1:0]           i_rs2_data,
    output logic [rv_pkg::reg_addr_bits-1:0] o_rs1,
    output logic [rv_pkg::reg_addr_bits-1:0] o_rs2,
    output logic                             o_valid,
    output rv_pkg::alu_op_t                  o_alu_op,
    output logic [rv_pkg::xlen-1:0]          o_op_a,
    output logic [rv_pkg::xlen-1:0]          o_op_b,
    output logic [rv_pkg::xlen-1:0]          o_rs1_val,
    output logic [rv_pkg::xlen-1:0]          o_rs2_val,
    output logic [rv_pkg::xlen-1:0]          o_imm,
    output logic [rv_pkg::xlen-1:0]          o_pc,
    output logic [rv_pkg::reg_addr_bits-1:0] o_rd,
    output logic                             o_reg_write,
    output logic [1:0]                       o_kind,
    output logic                             o_illegal
);

    rv_pkg::opcode_t opcode;
    rv_pkg::alu_op_t alu_op;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [4:0]  rd;
    logic        inst_full;
    logic [31:0] imm_i, imm_u, imm_b, imm_j, imm;
    logic        use_pc, use_zero, use_imm;
    logic        writes_rd, known, illegal, reg_write;
    logic [1:0]  kind;

    // shared funct3 map of the register and immediate forms
    function automatic rv_pkg::alu_op_t base_op(input logic [2:0] f3);
        case (f3)
            3'b000:  return rv_pkg::alu_add;
            3'b001:  return rv_pkg::alu_sll;
            3'b010:  return rv_pkg::alu_slt;
            3'b011:  return rv_pkg::alu_sltu;
            3'b100:  return rv_pkg::alu_xor;
            3'b101:  return rv_pkg::alu_srl;
            3'b110:  return rv_pkg::alu_or;
            default: return rv_pkg::alu_and;
        endcase
    endfunction

    assign opcode    = rv_pkg::opcode_t'(i_instruction[6:2]);
    assign inst_full = (i_instruction[1:0] == rv_pkg::opc_full_bits);
    assign rd        = i_instruction[11:7];
    assign funct3    = i_instruction[14:12];
    assign funct7    = i_instruction[31:25];
    assign o_rs1     = i_instruction[19:15];
    assign o_rs2     = i_instruction[24:20];

    assign imm_i = { {21{i_instruction[31]}}, i_instruction[30:20] };
    assign imm_u = { i_instruction[31:12], 12'b0 };
    assign imm_b = { {20{i_instruction[31]}}, i_instruction[7], i_instruction[30:25],
                     i_instruction[11:8], 1'b0 };
    assign imm_j = { {12{i_instruction[31]}}, i_instruction[19:12], i_instruction[20],
                     i_instruction[30:21], 1'b0 };

    always_comb
    begin
        alu_op    = rv_pkg::alu_add;
        imm       = imm_i;
        use_pc    = 1'b0;
        use_zero  = 1'b0;
        use_imm   = 1'b1;
        writes_rd = 1'b1;
        known     = 1'b1;
        kind      = rv_pkg::kind_other;
        case (opcode)
            rv_pkg::op_arr:
            begin
                use_imm = 1'b0;
                if (funct7 == rv_pkg::funct7_base)
                    alu_op = base_op(funct3);
                else if (funct7 == rv_pkg::funct7_alt && funct3 == 3'b000)
                    alu_op = rv_pkg::alu_sub;
                else if (funct7 == rv_pkg::funct7_alt && funct3 == 3'b101)
                    alu_op = rv_pkg::alu_sra;
                else
                    known = 1'b0;
            end
            rv_pkg::op_ari:
            begin
                alu_op = base_op(funct3);
                // shifts keep funct7 in the upper immediate bits
                if (funct3 == 3'b101 && funct7 == rv_pkg::funct7_alt)
                    alu_op = rv_pkg::alu_sra;
                else if (funct3[1:0] == 2'b01 && funct7 != rv_pkg::funct7_base)
                    known = 1'b0;
            end
            rv_pkg::op_lui:
            begin
                imm      = imm_u;
                use_zero = 1'b1;
            end
            rv_pkg::op_aui:
            begin
                imm    = imm_u;
                use_pc = 1'b1;
            end
            rv_pkg::op_b:
            begin
                imm       = imm_b;
                use_imm   = 1'b0;
                writes_rd = 1'b0;
                kind      = rv_pkg::kind_branch;
                case (funct3)
                    3'b000:  alu_op = rv_pkg::alu_eq;
                    3'b001:  alu_op = rv_pkg::alu_ne;
                    3'b100:  alu_op = rv_pkg::alu_lt;
                    3'b101:  alu_op = rv_pkg::alu_ge;
                    3'b110:  alu_op = rv_pkg::alu_ltu;
                    3'b111:  alu_op = rv_pkg::alu_geu;
                    default: known = 1'b0;
                endcase
            end
            rv_pkg::op_jal:
            begin
                imm    = imm_j;
                use_pc = 1'b1;
                kind   = rv_pkg::kind_jal;
            end
            rv_pkg::op_jalr:
            begin
                kind  = rv_pkg::kind_jalr;
                known = (funct3 == 3'b000);
            end
            default:
                known = 1'b0;
        endcase
    end

    assign illegal   = !(known && inst_full);
    // x0 is never written
    assign reg_write = !illegal && writes_rd && (rd != '0);

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_valid     <= 1'b0;
            o_reg_write <= 1'b0;
            o_illegal   <= 1'b0;
            o_kind      <= rv_pkg::kind_other;
        end
        else
        begin
            o_valid     <= i_valid;
            o_reg_write <= i_valid & reg_write;
            o_illegal   <= i_valid & illegal;
            o_kind      <= illegal ? rv_pkg::kind_other : kind;
        end
        o_alu_op  <= alu_op;
        o_op_a    <= use_zero ? '0 : (use_pc ? i_pc : i_rs1_data);
        o_op_b    <= use_imm ? imm : i_rs2_data;
        o_rs1_val <= i_rs1_data;
        o_rs2_val <= i_rs2_data;
        o_imm     <= imm;
        o_pc      <= i_pc;
        o_rd      <= rd;
    end

endmodule

// File: source/rv_execute.sv
`timescale 1ns/100ps

module rv_execute
(
    input  wire                              i_clk,
    input  wire                              i_reset,
    input  wire                              i_valid,
    input  rv_pkg::alu_op_t                  i_alu_op,
    input  wire [rv_pkg::xlen-1:0]           i_op_a,
    input  wire [rv_pkg::xlen-1:0]           i_op_b,
    input  wire [rv_pkg::xlen-1:0]           i_rs1_val,
    input  wire [rv_pkg::xlen-1:0]           i_rs2_val,
    input  wire [rv_pkg::xlen-1:0]           i_imm,
    input  wire [rv_pkg::xlen-1:0]           i_pc,
    input  wire [rv_pkg::reg_addr_bits-1:0]  i_rd,
    input  wire                              i_reg_write,
    input  wire [1:0]                        i_kind,
    input  wire                              i_illegal,
    output logic                             o_fwd_valid,
    output logic [rv_pkg::reg_addr_bits-1:0] o_fwd_rd,
    output logic [rv_pkg::xlen-1:0]          o_fwd_data,
    output logic                             o_wb_valid,
    output logic [rv_pkg::reg_addr_bits-1:0] o_wb_rd,
    output logic [rv_pkg::xlen-1:0]          o_wb_data,
    output logic                             o_wb_write,
    output logic                             o_branch_taken,
    output logic [rv_pkg::xlen-1:0]          o_branch_target,
    output logic                             o_illegal
);

    logic [rv_pkg::xlen-1:0] alu_res, result, target;
    logic                    is_jump, taken;

    // one comparator for set-less-than and the branches
    function automatic logic compare(input rv_pkg::alu_op_t op,
                                     input logic [rv_pkg::xlen-1:0] a,
                                     input logic [rv_pkg::xlen-1:0] b);
        case (op)
            rv_pkg::alu_eq:   return a == b;
            rv_pkg::alu_ne:   return a != b;
            rv_pkg::alu_slt,
            rv_pkg::alu_lt:   return $signed(a) < $signed(b);
            rv_pkg::alu_ge:   return $signed(a) >= $signed(b);
            rv_pkg::alu_sltu,
            rv_pkg::alu_ltu:  return a < b;
            rv_pkg::alu_geu:  return a >= b;
            default:          return 1'b0;
        endcase
    endfunction

    always_comb
    begin
        case (i_alu_op)
            rv_pkg::alu_add:  alu_res = i_op_a + i_op_b;
            rv_pkg::alu_sub:  alu_res = i_op_a - i_op_b;
            rv_pkg::alu_sll:  alu_res = i_op_a << i_op_b[4:0];
            rv_pkg::alu_srl:  alu_res = i_op_a >> i_op_b[4:0];
            rv_pkg::alu_sra:  alu_res = $signed(i_op_a) >>> i_op_b[4:0];
            rv_pkg::alu_and:  alu_res = i_op_a & i_op_b;
            rv_pkg::alu_or:   alu_res = i_op_a | i_op_b;
            rv_pkg::alu_xor:  alu_res = i_op_a ^ i_op_b;
            rv_pkg::alu_slt,
            rv_pkg::alu_sltu: alu_res = { {(rv_pkg::xlen-1){1'b0}},
                                          compare(i_alu_op, i_op_a, i_op_b) };
            default:          alu_res = '0;
        endcase
    end

    assign is_jump = (i_kind == rv_pkg::kind_jal) || (i_kind == rv_pkg::kind_jalr);
    assign taken   = is_jump ||
                     ((i_kind == rv_pkg::kind_branch) && compare(i_alu_op, i_rs1_val, i_rs2_val));

    // jumps add their offset in the alu, branches beside it
    assign target = is_jump ? { alu_res[rv_pkg::xlen-1:1], 1'b0 } : i_pc + i_imm;
    // link value for jal and jalr
    assign result = is_jump ? i_pc + rv_pkg::xlen'(rv_pkg::insn_bytes) : alu_res;

    assign o_fwd_valid = i_valid & i_reg_write;
    assign o_fwd_rd    = i_rd;
    assign o_fwd_data  = result;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_wb_valid     <= 1'b0;
            o_wb_write     <= 1'b0;
            o_branch_taken <= 1'b0;
            o_illegal      <= 1'b0;
        end
        else
        begin
            o_wb_valid     <= i_valid;
            o_wb_write     <= i_valid & i_reg_write;
            o_branch_taken <= i_valid & taken;
            o_illegal      <= i_valid & i_illegal;
        end
        o_wb_rd         <= i_rd;
        o_wb_data       <= result;
        o_branch_target <= target;
    end

endmodule

// File: source/rv_pkg.sv
package rv_pkg;

    // data path and pc width
    localparam int xlen          = 32;
    localparam int reg_addr_bits = 5;
    localparam int reg_count     = 32;

    // pc step of a full-length instruction
    localparam int insn_bytes = 4;

    // low opcode bits of a 32-bit encoding
    localparam logic [1:0] opc_full_bits = 2'b11;

    localparam logic [6:0] funct7_base = 7'b0000000;
    // sub and arithmetic right shift
    localparam logic [6:0] funct7_alt  = 7'b0100000;

    // kind of control transfer carried down the pipe
    localparam logic [1:0] kind_other  = 2'd0;
    localparam logic [1:0] kind_branch = 2'd1;
    localparam logic [1:0] kind_jal    = 2'd2;
    localparam logic [1:0] kind_jalr   = 2'd3;

    // major opcode, instruction bits 6:2
    typedef enum logic [4:0] {
        op_ari  = 5'b00100,
        op_aui  = 5'b00101,
        op_arr  = 5'b01100,
        op_lui  = 5'b01101,
        op_b    = 5'b11000,
        op_jalr = 5'b11001,
        op_jal  = 5'b11011
    } opcode_t;

    // alu operations, the last six are branch compares
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_eq,
        alu_ne,
        alu_lt,
        alu_ge,
        alu_ltu,
        alu_geu
    } alu_op_t;

endpackage

// File: source/rv_result.sv
`timescale 1ns/100ps

module rv_result
(
    input  wire                             i_clk,
    input  wire                             i_reset,
    input  wire [rv_pkg::reg_addr_bits-1:0] i_rs1,
    input  wire [rv_pkg::reg_addr_bits-1:0] i_rs2,
    input  wire                             i_fwd_valid,
    input  wire [rv_pkg::reg_addr_bits-1:0] i_fwd_rd,
    input  wire [rv_pkg::xlen-1:0]          i_fwd_data,
    input  wire                             i_wb_valid,
    input  wire                             i_wb_write,
    input  wire [rv_pkg::reg_addr_bits-1:0] i_wb_rd,
    input  wire [rv_pkg::xlen-1:0]          i_wb_data,
    output logic [rv_pkg::xlen-1:0]         o_rs1_data,
    output logic [rv_pkg::xlen-1:0]         o_rs2_data
);

    // x0 has no storage
    logic [rv_pkg::xlen-1:0] regs [1:rv_pkg::reg_count-1];
    logic                    wb_en;

    assign wb_en = i_wb_valid && i_wb_write && (i_wb_rd != '0);

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            for (int i = 1; i < rv_pkg::reg_count; i++)
                regs[i] <= '0;
        end
        else if (wb_en)
        begin
            regs[i_wb_rd] <= i_wb_data;
        end
    end

    // newest value wins, decode register first, then execute register
    function automatic logic [rv_pkg::xlen-1:0] read_port(
        input logic [rv_pkg::reg_addr_bits-1:0] addr);
        if (addr == '0)
            return '0;
        if (i_fwd_valid && i_fwd_rd == addr)
            return i_fwd_data;
        if (wb_en && i_wb_rd == addr)
            return i_wb_data;
        return regs[addr];
    endfunction

    always_comb
    begin
        o_rs1_data = read_port(i_rs1);
        o_rs2_data = read_port(i_rs2);
    end

endmodule

// File: verif/rv_tb_model.svh
`ifndef rv_tb_model_svh
`define rv_tb_model_svh

// expected report of one input cycle, due is the time it is checked
typedef struct packed {
    logic        valid;
    logic        write;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        taken;
    logic [31:0] target;
    logic        illegal;
    logic [63:0] due;
} report_t;

logic [16:0] lfsr_state;
logic [31:0] model_regs [0:31];

// fibonacci lfsr, x^17 + x^14 + 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
        lfsr_state = {lfsr_state[15:0], lfsr_state[16] ^ lfsr_state[13]};
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

// classes: 0 reg-reg, 1 reg-imm, 2 lui, 3 auipc, 4 jal, 5 jalr, 6 branch, 7 bad funct7
function automatic logic [2:0] pick_class(input logic [7:0] mask);
    logic [2:0] cls;
    cls = 3'(rand_bits(3));
    while (!mask[cls])
        cls = 3'(rand_bits(3));
    return cls;
endfunction

function automatic logic [31:0] gen_insn(input logic [2:0] cls);
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] hi, lo;
    // registers 0 to 7 only, so dependences are frequent
    rd  = 5'(rand_bits(3));
    rs1 = 5'(rand_bits(3));
    rs2 = 5'(rand_bits(3));
    f3  = 3'(rand_bits(3));
    f7  = 7'h00;
    if ((f3 == 3'd0 || f3 == 3'd5) && rand_bits(1) == 1)
        f7 = 7'h20;
    hi = rand_bits(20);
    lo = rand_bits(5);
    case (cls)
        3'd0: return {f7, rs2, rs1, f3, rd, 7'b0110011};
        3'd1:
        begin
            if (f3 == 3'd1 || f3 == 3'd5)
                return {f7, lo[4:0], rs1, f3, rd, 7'b0010011};
            return {hi[11:0], rs1, f3, rd, 7'b0010011};
        end
        3'd2: return {hi[19:0], rd, 7'b0110111};
        3'd3: return {hi[19:0], rd, 7'b0010111};
        3'd4: return {hi[19:0], rd, 7'b1101111};
        3'd5: return {hi[11:0], rs1, 3'b000, rd, 7'b1100111};
        3'd6:
        begin
            // funct3 2 and 3 are no branch, move them up to 6 and 7
            if (f3[2:1] == 2'b01)
                f3[2] = 1'b1;
            return {hi[6:0], rs2, rs1, f3, lo[4:0], 7'b1100011};
        end
        default: return {hi[5:0], 1'b1, rs2, rs1, f3, rd, 7'b0110011};
    endcase
endfunction

function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return {31'b0, $signed(a) < $signed(b)};
        3'd3: return {31'b0, a < b};
        3'd4: return a ^ b;
        3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

// runs one instruction in program order on the model register file
function automatic report_t model_exec(input logic [31:0] insn, input logic [31:0] pc);
    report_t     r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a, b, imm_i, imm_u;
    logic        ok, alt;
    f3      = insn[14:12];
    f7      = insn[31:25];
    a       = model_regs[insn[19:15]];
    b       = model_regs[insn[24:20]];
    imm_i   = {{20{insn[31]}}, insn[31:20]};
    imm_u   = {insn[31:12], 12'b0};
    r       = '0;
    r.valid = 1'b1;
    r.write = 1'b1;
    r.rd    = insn[11:7];
    ok      = 1'b1;
    case (insn[6:0])
        7'b0110011:
        begin
            ok     = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            r.data = alu_result(f3, f7[5], a, b);
        end
        7'b0010011:
        begin
            // shift immediates carry a funct7 in their upper bits
            alt = (f3 == 3'd5) && (f7 == 7'h20);
            if (f3 == 3'd1 || f3 == 3'd5)
                ok = (f7 == 7'h00) || alt;
            r.data = alu_result(f3, alt, a, imm_i);
        end
        7'b0110111: r.data = imm_u;
        7'b0010111: r.data = pc + imm_u;
        7'b1101111:
        begin
            r.data   = pc + 4;
            r.taken  = 1'b1;
            r.target = pc + {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
        end
        7'b1100111:
        begin
            ok       = (f3 == 3'd0);
            r.data   = pc + 4;
            r.taken  = 1'b1;
            r.target = (a + imm_i) & ~32'd1;
        end
        7'b1100011:
        begin
            r.write  = 1'b0;
            r.target = pc + {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
            case (f3)
                3'd0: r.taken = (a == b);
                3'd1: r.taken = (a != b);
                3'd4: r.taken = ($signed(a) < $signed(b));
                3'd5: r.taken = ($signed(a) >= $signed(b));
                3'd6: r.taken = (a < b);
                3'd7: r.taken = (a >= b);
                default: ok = 1'b0;
            endcase
        end
        default: ok = 1'b0;
    endcase
    if (!ok)
    begin
        r.illegal = 1'b1;
        r.write   = 1'b0;
        r.taken   = 1'b0;
    end
    // x0 stays zero
    if (r.rd == 5'd0)
        r.write = 1'b0;
    if (r.write)
        model_regs[r.rd] = r.data;
    return r;
endfunction

`endif

// File: verif/rv_core_tb.sv
`timescale 1ns/100ps

module rv_core_tb;

    // input cycles per test
    localparam int n_regs   = 32;
    localparam int n_alu    = 200;
    localparam int n_jump   = 60;
    localparam int n_branch = 60;
    localparam int n_bad    = 60;
    localparam int n_gap    = 100;
    // every test drains the pipe for a few cycles, reset takes 3
    localparam int watchdog_cycles = n_regs + n_alu + n_jump + n_branch + n_bad + n_gap
                                     + 6 * 4 + 3 + 20;

    logic        i_clk;
    logic        i_reset;
    logic        i_valid;
    logic [31:0] i_instruction;
    logic [31:0] i_pc;
    logic        o_wb_valid;
    logic [4:0]  o_wb_rd;
    logic [31:0] o_wb_data;
    logic        o_wb_write;
    logic        o_branch_taken;
    logic [31:0] o_branch_target;
    logic        o_illegal;

    logic [31:0] pc;
    int          checks;
    int          errors;
    int          tests;
    int          test_checks;
    int          test_errors;

    `include "rv_tb_model.svh"

    report_t exp_q[$];

    rv_core u_dut (
        .i_clk(i_clk), .i_reset(i_reset), .i_valid(i_valid),
        .i_instruction(i_instruction), .i_pc(i_pc),
        .o_wb_valid(o_wb_valid), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data),
        .o_wb_write(o_wb_write), .o_branch_taken(o_branch_taken),
        .o_branch_target(o_branch_target), .o_illegal(o_illegal)
    );

    initial
    begin
        i_clk = 1'b0;
        forever
            #50 i_clk = ~i_clk;
    end

    initial
    begin
        #(watchdog_cycles * 100);
        $display("run timed out after %0d cycles", watchdog_cycles);
        $display(">>> FAIL");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        test_checks++;
        if (actual !== expected)
        begin
            test_errors++;
            $display("Error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_report(input report_t r);
        check_value("o_wb_valid", 32'(r.valid), 32'(o_wb_valid));
        check_value("o_wb_write", 32'(r.write), 32'(o_wb_write));
        check_value("o_branch_taken", 32'(r.taken), 32'(o_branch_taken));
        check_value("o_illegal", 32'(r.illegal), 32'(o_illegal));
        if (r.write)
        begin
            check_value("o_wb_rd", 32'(r.rd), 32'(o_wb_rd));
            check_value("o_wb_data", r.data, o_wb_data);
        end
        if (r.taken)
            check_value("o_branch_target", r.target, o_branch_target);
    endtask

    // one input cycle, idle cycles expect no report
    task automatic issue(input logic valid, input logic [31:0] insn);
        report_t r;
        @(posedge i_clk);
        #10;
        i_valid       = valid;
        i_instruction = insn;
        i_pc          = pc;
        if (valid)
            r = model_exec(insn, pc);
        else
            r = '0;
        // accepted at the next edge, reported one edge later
        r.due = $time + 240;
        exp_q.push_back(r);
        if (valid)
            pc = pc + 4;
    endtask

    task automatic finish_test(input string name);
        issue(1'b0, '0);
        while (exp_q.size() != 0)
            @(posedge i_clk);
        $display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
        checks      += test_checks;
        errors      += test_errors;
        tests++;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic run_random(input string name, input int n, input logic [7:0] mask,
                              input logic gaps);
        for (int k = 0; k < n; k++)
        begin
            // idle cycles carry junk the core must ignore
            if (gaps && rand_bits(2) == 0)
                issue(1'b0, rand_bits(32));
            else
                issue(1'b1, gen_insn(pick_class(mask)));
        end
        finish_test(name);
    endtask

    // mid-cycle, outputs are settled
    initial
    begin
        report_t r;
        forever
        begin
            @(posedge i_clk);
            #50;
            while (exp_q.size() != 0 && exp_q[0].due <= $time)
            begin
                r = exp_q.pop_front();
                check_report(r);
            end
        end
    end

    initial
    begin
        lfsr_state    = 17'd65833;
        pc            = 32'h0000_1000;
        i_reset       = 1'b1;
        i_valid       = 1'b0;
        i_instruction = '0;
        i_pc          = '0;
        for (int k = 0; k < 32; k++)
            model_regs[5'(k)] = '0;
        repeat (3) @(posedge i_clk);
        #10;
        i_reset = 1'b0;
        check_value("o_wb_valid", 0, 32'(o_wb_valid));
        check_value("o_wb_write", 0, 32'(o_wb_write));
        check_value("o_branch_taken", 0, 32'(o_branch_taken));
        check_value("o_illegal", 0, 32'(o_illegal));
        // or xk, xk, xk reads back every register
        for (int k = 0; k < n_regs; k++)
            issue(1'b1, {7'h00, 5'(k), 5'(k), 3'b110, 5'(k), 7'b0110011});
        finish_test("reset state");
        run_random("alu back to back", n_alu, 8'b0000_0011, 1'b0);
        run_random("upper and jumps", n_jump, 8'b0011_1111, 1'b0);
        run_random("branches", n_branch, 8'b0100_0011, 1'b0);
        run_random("illegal and x0", n_bad, 8'b1111_1111, 1'b0);
        run_random("valid gaps", n_gap, 8'b0111_1111, 1'b1);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule
